// ==== source/rob_defines.svh ====
// Core sizing macros for the rename, reorder and retire core
// Slot counts per cycle, storage depths and the index widths built from them

`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// ==================================================
// Slots per cycle
// ==================================================
// Instructions renamed and dispatched per cycle
`define DP_WIDTH            2
// Instructions retired per cycle
`define RT_WIDTH            2
// Completion notices accepted per cycle
`define CDB_WIDTH           2

// ==================================================
// Storage depths
// ==================================================
`define ROB_ENTRY_NUM       32
`define ARCH_REG_NUM        32
`define PHY_REG_NUM         64

// ==================================================
// Derived index widths
// ==================================================
`define ARCH_REG_IDX_WIDTH  $clog2(`ARCH_REG_NUM)
`define TAG_IDX_WIDTH       $clog2(`PHY_REG_NUM)
`define ROB_IDX_WIDTH       $clog2(`ROB_ENTRY_NUM)

`endif

// ==== source/rob_pkg.sv ====
// Shared types of the rename, reorder and retire core
// Index vectors plus the records passed between the three stages

`include "rob_defines.svh"

package rob_pkg;

    // ==================================================
    // Index vectors
    // ==================================================
    // Architectural register number
    typedef logic [`ARCH_REG_IDX_WIDTH-1:0] arch_reg_t;
    // Physical register tag
    typedef logic [`TAG_IDX_WIDTH-1:0]      tag_t;
    // Reorder buffer slot number
    typedef logic [`ROB_IDX_WIDTH-1:0]      rob_idx_t;

    // ==================================================
    // Stage to stage records
    // ==================================================
    // Renamed instruction from rename into the reorder buffer
    // Valid means the slot was accepted this cycle
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_reg;
        tag_t      tag;
        tag_t      tag_old;
    } dp_rob_t;

    // Completion notice for one reorder buffer entry
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } cdb_t;

    // Instruction leaving the reorder buffer in program order
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_reg;
        tag_t      tag;
        tag_t      tag_old;
    } retire_t;

    // Tag handed back to the free list
    typedef struct packed {
        logic valid;
        tag_t tag;
    } free_t;

endpackage

// ==== source/rename_stage.sv ====
// Rename stage
// Gives each dispatched instruction a fresh physical tag from a FIFO free list
// and looks up the previous tag of its destination in the speculative map table

`timescale 1ns/100ps
`include "rob_defines.svh"

module rename_stage (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic             [`DP_WIDTH-1:0]     dp_valid_i,
    input  rob_pkg::arch_reg_t [`DP_WIDTH-1:0]   dp_arch_reg_i,
    input  logic             [`DP_WIDTH-1:0]     rob_ready_i,
    input  rob_pkg::free_t   [`RT_WIDTH-1:0]     free_i,
    output logic             [`DP_WIDTH-1:0]     dp_ready_o,
    output rob_pkg::dp_rob_t [`DP_WIDTH-1:0]     dp_rob_o
);
    import rob_pkg::*;

    // Free list holds every tag not mapped architecturally
    localparam int FL_DEPTH = `PHY_REG_NUM - `ARCH_REG_NUM;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    localparam int CNT_W    = $clog2(`DP_WIDTH) + 1;

    // Speculative map table
    tag_t smt [`ARCH_REG_NUM];

    // Free list storage and pointers
    tag_t                fl_mem [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_rd_ptr;
    logic [FL_PTR_W-1:0] fl_wr_ptr;
    logic [FL_PTR_W:0]   fl_count;
    logic [`DP_WIDTH-1:0] fl_ready;

    // Per slot acceptance and renaming results
    logic [`DP_WIDTH-1:0] dp_acc;
    tag_t                 new_tag [`DP_WIDTH];
    logic [CNT_W-1:0]     pop_cnt;
    logic [CNT_W-1:0]     push_cnt;
    logic [FL_PTR_W-1:0]  push_ptr [`RT_WIDTH];

    // ==================================================
    // Dispatch readiness
    // ==================================================
    // Bottom-up ready from the free list occupancy
    always_comb begin
        for (int k = 0; k < `DP_WIDTH; k++) begin
            fl_ready[k] = (fl_count > k);
        end
    end

    // Both the buffer and the free list must have room
    assign dp_ready_o = rob_ready_i & fl_ready;
    assign dp_acc     = dp_valid_i & dp_ready_o;

    // ==================================================
    // Tag assignment and old tag lookup
    // ==================================================
    always_comb begin
        pop_cnt = '0;
        for (int k = 0; k < `DP_WIDTH; k++) begin
            // Next unused tag from the free list head
            new_tag[k] = fl_mem[fl_rd_ptr + FL_PTR_W'(pop_cnt)];
            dp_rob_o[k].valid    = dp_acc[k];
            dp_rob_o[k].arch_reg = dp_arch_reg_i[k];
            dp_rob_o[k].tag      = new_tag[k];
            // Older slot in the same cycle overrides the table
            dp_rob_o[k].tag_old  = smt[dp_arch_reg_i[k]];
            for (int j = 0; j < k; j++) begin
                if (dp_acc[j] && (dp_arch_reg_i[j] == dp_arch_reg_i[k])) begin
                    dp_rob_o[k].tag_old = new_tag[j];
                end
            end
            pop_cnt = pop_cnt + CNT_W'(dp_acc[k]);
        end
    end

    // Write slots for returned tags, slot 0 first
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < `RT_WIDTH; k++) begin
            push_ptr[k] = fl_wr_ptr + FL_PTR_W'(push_cnt);
            push_cnt    = push_cnt + CNT_W'(free_i[k].valid);
        end
    end

    // ==================================================
    // Speculative map table update
    // ==================================================
    // Identity map after reset, younger slot wins on a collision
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                smt[i] <= tag_t'(i);
            end
        end else begin
            for (int k = 0; k < `DP_WIDTH; k++) begin
                if (dp_acc[k]) begin
                    smt[dp_arch_reg_i[k]] <= new_tag[k];
                end
            end
        end
    end

    // ==================================================
    // Free list FIFO
    // ==================================================
    // Starts full with the upper half of the tag space in order
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fl_rd_ptr <= '0;
            fl_wr_ptr <= '0;
            fl_count  <= (FL_PTR_W+1)'(FL_DEPTH);
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= tag_t'(`ARCH_REG_NUM + i);
            end
        end else begin
            fl_rd_ptr <= fl_rd_ptr + FL_PTR_W'(pop_cnt);
            fl_wr_ptr <= fl_wr_ptr + FL_PTR_W'(push_cnt);
            fl_count  <= fl_count + (FL_PTR_W+1)'(push_cnt) - (FL_PTR_W+1)'(pop_cnt);
            for (int k = 0; k < `RT_WIDTH; k++) begin
                if (free_i[k].valid) begin
                    fl_mem[push_ptr[k]] <= free_i[k].tag;
                end
            end
        end
    end

endmodule

// ==== source/rob.sv ====
// Reorder buffer
// Circular buffer of renamed instructions kept in program order
// Entries are marked done out of order and leave from the head in order

`timescale 1ns/100ps
`include "rob_defines.svh"

module rob (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  rob_pkg::dp_rob_t  [`DP_WIDTH-1:0]   dp_rob_i,
    input  rob_pkg::cdb_t     [`CDB_WIDTH-1:0]  cdb_i,
    output logic              [`DP_WIDTH-1:0]   rob_ready_o,
    output rob_pkg::rob_idx_t [`DP_WIDTH-1:0]   rob_idx_o,
    output rob_pkg::retire_t  [`RT_WIDTH-1:0]   rt_o
);
    import rob_pkg::*;

    localparam int IDX_W = `ROB_IDX_WIDTH;
    // Pointers carry one extra wrap bit
    localparam int PTR_W = IDX_W + 1;

    // Payload of one entry
    typedef struct packed {
        arch_reg_t arch_reg;
        tag_t      tag;
        tag_t      tag_old;
    } rob_entry_t;

    // ==================================================
    // Storage and pointers
    // ==================================================
    rob_entry_t                 ent_data [`ROB_ENTRY_NUM];
    logic [`ROB_ENTRY_NUM-1:0]  ent_valid;
    logic [`ROB_ENTRY_NUM-1:0]  ent_complete;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] used_num;
    logic [PTR_W-1:0] free_num;

    // Dispatch placement
    rob_idx_t dp_idx [`DP_WIDTH];
    rob_idx_t dp_cnt;

    // Retire selection
    rob_idx_t rt_ptr [`RT_WIDTH];
    rob_idx_t rt_cnt;

    // ==================================================
    // Occupancy and ready
    // ==================================================
    // Wrap bit makes the plain difference exact for full and empty
    assign used_num = tail - head;
    assign free_num = PTR_W'(`ROB_ENTRY_NUM) - used_num;

    // Ready bits fill from slot 0 upward
    always_comb begin
        for (int k = 0; k < `DP_WIDTH; k++) begin
            rob_ready_o[k] = (free_num > k);
        end
    end

    // Accepted slots take consecutive entries from the tail
    always_comb begin
        dp_cnt = '0;
        for (int k = 0; k < `DP_WIDTH; k++) begin
            dp_idx[k]    = tail[IDX_W-1:0] + dp_cnt;
            rob_idx_o[k] = dp_idx[k];
            dp_cnt       = dp_cnt + rob_idx_t'(dp_rob_i[k].valid);
        end
    end

    // ==================================================
    // In-order retire selection
    // ==================================================
    // A slot retires only if every entry from the head up to it is done
    always_comb begin
        logic chain;
        chain  = 1'b1;
        rt_cnt = '0;
        for (int k = 0; k < `RT_WIDTH; k++) begin
            rt_ptr[k] = head[IDX_W-1:0] + rob_idx_t'(k);
            chain     = chain & ent_valid[rt_ptr[k]] & ent_complete[rt_ptr[k]];
            rt_o[k].valid    = chain;
            rt_o[k].arch_reg = ent_data[rt_ptr[k]].arch_reg;
            rt_o[k].tag      = ent_data[rt_ptr[k]].tag;
            rt_o[k].tag_old  = ent_data[rt_ptr[k]].tag_old;
            rt_cnt = rt_cnt + rob_idx_t'(chain);
        end
    end

    // ==================================================
    // Entry state and pointer update
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head         <= '0;
            tail         <= '0;
            ent_valid    <= '0;
            ent_complete <= '0;
        end else begin
            head <= head + PTR_W'(rt_cnt);
            tail <= tail + PTR_W'(dp_cnt);
            // Completion notices in any order
            for (int c = 0; c < `CDB_WIDTH; c++) begin
                if (cdb_i[c].valid) begin
                    ent_complete[cdb_i[c].rob_idx] <= 1'b1;
                end
            end
            // Retired entries become free
            for (int k = 0; k < `RT_WIDTH; k++) begin
                if (rt_o[k].valid) begin
                    ent_valid[rt_ptr[k]]    <= 1'b0;
                    ent_complete[rt_ptr[k]] <= 1'b0;
                end
            end
            // New entries start not done
            for (int k = 0; k < `DP_WIDTH; k++) begin
                if (dp_rob_i[k].valid) begin
                    ent_valid[dp_idx[k]]    <= 1'b1;
                    ent_complete[dp_idx[k]] <= 1'b0;
                end
            end
        end
    end

    // Payload written at dispatch
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `DP_WIDTH; k++) begin
            if (dp_rob_i[k].valid) begin
                ent_data[dp_idx[k]].arch_reg <= dp_rob_i[k].arch_reg;
                ent_data[dp_idx[k]].tag      <= dp_rob_i[k].tag;
                ent_data[dp_idx[k]].tag_old  <= dp_rob_i[k].tag_old;
            end
        end
    end

endmodule

// ==== source/retire_stage.sv ====
// Retire stage
// Commits retiring tags to the architectural map table and
// returns each displaced tag to the free list

`timescale 1ns/100ps
`include "rob_defines.svh"

module retire_stage (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  rob_pkg::retire_t [`RT_WIDTH-1:0]   rt_i,
    input  rob_pkg::arch_reg_t                 amt_rd_idx_i,
    output rob_pkg::free_t   [`RT_WIDTH-1:0]   free_o,
    output rob_pkg::tag_t                      amt_rd_tag_o
);
    import rob_pkg::*;

    // Architectural map table
    tag_t amt [`ARCH_REG_NUM];

    // ==================================================
    // Map table update
    // ==================================================
    // Identity map after reset
    // Slots are applied in order so the younger retire wins
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `ARCH_REG_NUM; i++) begin
                amt[i] <= tag_t'(i);
            end
        end else begin
            for (int k = 0; k < `RT_WIDTH; k++) begin
                if (rt_i[k].valid) begin
                    amt[rt_i[k].arch_reg] <= rt_i[k].tag;
                end
            end
        end
    end

    // ==================================================
    // Freed tags and read port
    // ==================================================
    // Old mapping is dead once its successor retires
    always_comb begin
        for (int k = 0; k < `RT_WIDTH; k++) begin
            free_o[k].valid = rt_i[k].valid;
            free_o[k].tag   = rt_i[k].tag_old;
        end
    end

    // Committed mapping of one register
    assign amt_rd_tag_o = amt[amt_rd_idx_i];

endmodule

// ==== source/rob_core.sv ====
// Rename, reorder and retire core
// Chains the rename stage, the reorder buffer and the retire stage

`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_core (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // Dispatch
    input  logic               [`DP_WIDTH-1:0]  dp_valid_i,
    input  rob_pkg::arch_reg_t [`DP_WIDTH-1:0]  dp_arch_reg_i,
    output logic               [`DP_WIDTH-1:0]  dp_ready_o,
    output rob_pkg::tag_t      [`DP_WIDTH-1:0]  dp_tag_o,
    output rob_pkg::rob_idx_t  [`DP_WIDTH-1:0]  dp_rob_idx_o,
    // Completion
    input  rob_pkg::cdb_t      [`CDB_WIDTH-1:0] cdb_i,
    // Retire
    output rob_pkg::retire_t   [`RT_WIDTH-1:0]  rt_o,
    // Architectural map read port
    input  rob_pkg::arch_reg_t                  amt_rd_idx_i,
    output rob_pkg::tag_t                       amt_rd_tag_o
);
    import rob_pkg::*;

    // ==================================================
    // Inter-stage wires
    // ==================================================
    dp_rob_t [`DP_WIDTH-1:0] dp_rob;
    logic    [`DP_WIDTH-1:0] rob_ready;
    free_t   [`RT_WIDTH-1:0] free;

    // Tag given to each accepted slot
    always_comb begin
        for (int k = 0; k < `DP_WIDTH; k++) begin
            dp_tag_o[k] = dp_rob[k].tag;
        end
    end

    // Producer side
    rename_stage u_rename (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dp_valid_i    (dp_valid_i),
        .dp_arch_reg_i (dp_arch_reg_i),
        .rob_ready_i   (rob_ready),
        .free_i        (free),
        .dp_ready_o    (dp_ready_o),
        .dp_rob_o      (dp_rob)
    );

    // Program order buffer
    rob u_rob (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dp_rob_i    (dp_rob),
        .cdb_i       (cdb_i),
        .rob_ready_o (rob_ready),
        .rob_idx_o   (dp_rob_idx_o),
        .rt_o        (rt_o)
    );

    // Consumer side
    retire_stage u_retire (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rt_i         (rt_o),
        .amt_rd_idx_i (amt_rd_idx_i),
        .free_o       (free),
        .amt_rd_tag_o (amt_rd_tag_o)
    );

endmodule

// ==== verif/rob_core_tb.sv ====
// Testbench for the rename, reorder and retire core
// Random dispatch and shuffled completion checked against a map table reference

`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_core_tb;
    import rob_pkg::*;

    localparam int N_INSTR = 400;
    localparam int TIMEOUT = N_INSTR * 8 + 1000;

    logic                        clk_i;
    logic                        rst_i;
    logic      [`DP_WIDTH-1:0]   dp_valid_i;
    arch_reg_t [`DP_WIDTH-1:0]   dp_arch_reg_i;
    logic      [`DP_WIDTH-1:0]   dp_ready_o;
    tag_t      [`DP_WIDTH-1:0]   dp_tag_o;
    rob_idx_t  [`DP_WIDTH-1:0]   dp_rob_idx_o;
    cdb_t      [`CDB_WIDTH-1:0]  cdb_i;
    retire_t   [`RT_WIDTH-1:0]   rt_o;
    arch_reg_t                   amt_rd_idx_i;
    tag_t                        amt_rd_tag_o;

    // Stimulus side
    arch_reg_t arch_seq [N_INSTR+2];
    rob_idx_t  pending [$];
    int        issued;
    logic      fill_phase;

    // Reference state indexed by program order
    arch_reg_t rec_arch [N_INSTR];
    tag_t      rec_tag [N_INSTR];
    logic      done [N_INSTR];
    int        inst_of_idx [`ROB_ENTRY_NUM];
    tag_t      free_q [$];
    int        disp_cnt;
    int        ret_cnt;
    logic      saw_full;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    rob_core u_dut (.*);

    // Latest tag given to a register by the first upto instructions
    function automatic tag_t ref_mapping(input int upto, input arch_reg_t r);
        for (int i = upto - 1; i >= 0; i--) begin
            if (rec_arch[i] == r) begin
                return rec_tag[i];
            end
        end
        // Untouched registers keep the identity map
        return tag_t'(r);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0.1f ns: %s is %0d, expected %0d",
                     $realtime, what, got, exp);
        end
    endtask

    // ==================================================
    // Clock, reset and run control
    // ==================================================
    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    initial begin
        rst_i        <= 1'b1;
        amt_rd_idx_i <= '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        while (ret_cnt < N_INSTR) begin
            @(posedge clk_i);
        end
        // Committed map must hold the last renaming of every register
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            @(posedge clk_i);
            amt_rd_idx_i <= arch_reg_t'(r);
            @(negedge clk_i);
            check_value($sformatf("amt_rd_tag_o for r%0d", r), amt_rd_tag_o,
                        ref_mapping(disp_cnt, arch_reg_t'(r)));
        end
        if (!saw_full) begin
            errors++;
            $display("Dispatch never stalled on a full reorder buffer");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // ==================================================
    // Producer and shuffled completer
    // ==================================================
    initial begin
        int r;
        int n_off;
        int n_cmp;
        int j;
        void'($urandom(32'h76bf754a));
        issued        = 0;
        fill_phase    = 1'b1;
        dp_valid_i    <= '0;
        dp_arch_reg_i <= '0;
        cdb_i         <= '0;
        // Now and then repeat a register so one cycle renames it twice
        for (int i = 0; i < N_INSTR + 2; i++) begin
            if (i > 0 && $urandom_range(0, 7) == 0) begin
                arch_seq[i] = arch_seq[i-1];
            end else begin
                arch_seq[i] = arch_reg_t'($urandom_range(0, `ARCH_REG_NUM - 1));
            end
        end
        forever begin
            @(posedge clk_i);
            if (!rst_i) begin
                // Accepted slots leave the offer and their index waits for completion
                for (int k = 0; k < `DP_WIDTH; k++) begin
                    if (dp_valid_i[k] && dp_ready_o[k]) begin
                        issued++;
                        pending.push_back(dp_rob_idx_o[k]);
                    end
                end
                r     = $urandom_range(0, 7);
                n_off = (r == 0) ? 0 : ((r == 1) ? 1 : 2);
                // Refused instructions stay on offer
                if ((dp_valid_i & ~dp_ready_o) != '0) begin
                    n_off = 2;
                end
                if (n_off > N_INSTR - issued) begin
                    n_off = N_INSTR - issued;
                end
                for (int k = 0; k < `DP_WIDTH; k++) begin
                    dp_valid_i[k]    <= (k < n_off);
                    dp_arch_reg_i[k] <= arch_seq[issued + k];
                end
                // No completions until the buffer has filled once
                if (pending.size() >= `ROB_ENTRY_NUM) begin
                    fill_phase = 1'b0;
                end
                n_cmp = fill_phase ? 0 : $urandom_range(0, `CDB_WIDTH);
                for (int c = 0; c < `CDB_WIDTH; c++) begin
                    cdb_i[c].valid <= 1'b0;
                    if (c < n_cmp && pending.size() > 0) begin
                        j = $urandom_range(0, pending.size() - 1);
                        cdb_i[c].valid   <= 1'b1;
                        cdb_i[c].rob_idx <= pending[j];
                        pending.delete(j);
                    end
                end
            end
        end
    end

    // ==================================================
    // Compare process
    // ==================================================
    always @(posedge clk_i) begin
        logic [`DP_WIDTH-1:0] exp_rdy;
        logic                 chain;
        tag_t                 exp_tag;
        tag_t                 freed [$];
        int                   n;
        if (rst_i) begin
            // Free list starts with the upper tags in order
            free_q   = {};
            for (int i = `ARCH_REG_NUM; i < `PHY_REG_NUM; i++) begin
                free_q.push_back(tag_t'(i));
            end
            disp_cnt = 0;
            ret_cnt  = 0;
            saw_full = 1'b0;
        end else begin
            // Ready bounded by free buffer entries and free tags
            for (int k = 0; k < `DP_WIDTH; k++) begin
                exp_rdy[k] = (`ROB_ENTRY_NUM - (disp_cnt - ret_cnt) > k) && (free_q.size() > k);
            end
            check_value("dp_ready_o", dp_ready_o, exp_rdy);
            if (exp_rdy == '0) begin
                saw_full = 1'b1;
            end
            // Retire valid only along the done chain from the oldest entry
            chain = 1'b1;
            freed = {};
            for (int k = 0; k < `RT_WIDTH; k++) begin
                n     = ret_cnt + k;
                chain = chain && (n < disp_cnt) && done[n];
                check_value($sformatf("rt_o[%0d].valid", k), rt_o[k].valid, chain);
                if (chain) begin
                    check_value($sformatf("rt_o[%0d].arch_reg", k), rt_o[k].arch_reg, rec_arch[n]);
                    check_value($sformatf("rt_o[%0d].tag", k), rt_o[k].tag, rec_tag[n]);
                    check_value($sformatf("rt_o[%0d].tag_old", k), rt_o[k].tag_old,
                                ref_mapping(n, rec_arch[n]));
                    freed.push_back(ref_mapping(n, rec_arch[n]));
                end
            end
            ret_cnt = ret_cnt + freed.size();
            // Accepted slots take the free list head and the next buffer slot
            for (int k = 0; k < `DP_WIDTH; k++) begin
                if (dp_valid_i[k] && dp_ready_o[k]) begin
                    exp_tag = free_q.pop_front();
                    check_value($sformatf("dp_tag_o[%0d]", k), dp_tag_o[k], exp_tag);
                    check_value($sformatf("dp_rob_idx_o[%0d]", k), dp_rob_idx_o[k],
                                disp_cnt % `ROB_ENTRY_NUM);
                    rec_arch[disp_cnt] = dp_arch_reg_i[k];
                    rec_tag[disp_cnt]  = exp_tag;
                    done[disp_cnt]     = 1'b0;
                    inst_of_idx[disp_cnt % `ROB_ENTRY_NUM] = disp_cnt;
                    disp_cnt++;
                end
            end
            // Old tags return behind this cycle's pops
            foreach (freed[i]) begin
                free_q.push_back(freed[i]);
            end
            for (int c = 0; c < `CDB_WIDTH; c++) begin
                if (cdb_i[c].valid) begin
                    done[inst_of_idx[cdb_i[c].rob_idx]] = 1'b1;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

// ==== rob_core.f ====
+incdir+source
source/rob_pkg.sv
source/rename_stage.sv
source/rob.sv
source/retire_stage.sv
source/rob_core.sv
verif/rob_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the rename, reorder and retire core testbench

TOP := rob_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f rob_core.f

# Pass only when the testbench printed the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
